/* hw/div_pkg.sv */
`default_nettype none

package div_pkg;

  // ==================================================
  // datapath widths
  // ==================================================
  parameter int DIVIDEND_W = 16;
  parameter int DIVISOR_W  = 8;   // also quotient and remainder.
  parameter int ERR_W      = 24;  // error sum accumulator.
  parameter int CNT_W      = 16;  // mismatch counter.

  // ==================================================
  // opcodes and controller states
  // ==================================================
  typedef enum logic [1:0] {
    op_exact   = 2'd0,
    op_approx  = 2'd1,
    op_compare = 2'd2,  // both arrays, updates statistics.
    op_clear   = 2'd3
  } div_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/exact_array_div.sv */
`default_nettype none

module exact_array_div (
  input  wire [div_pkg::DIVIDEND_W-1:0] n,
  input  wire [div_pkg::DIVISOR_W-1:0]  d,
  output wire [div_pkg::DIVISOR_W-1:0]  q,
  output wire [div_pkg::DIVISOR_W-1:0]  r
);

  localparam int W = div_pkg::DIVISOR_W;

  wire [W-1:0] x_in  [W];
  wire [W-1:0] b_out [W];
  wire [W-1:0] rem   [W];

  // ==================================================
  // restoring array, exact borrow cells only
  // ==================================================
  for (genvar i = 0; i < W; i++) begin : g_row
    for (genvar j = 0; j < W; j++) begin : g_col
      wire b_in;
      wire diff;

      if (j == 0) begin : g_lsb
        assign x_in[i][j] = n[i];
        assign b_in       = 1'b0;
      end else if (i == W-1) begin : g_top
        assign x_in[i][j] = n[W-1+j];
        assign b_in       = b_out[i][j-1];
      end else begin : g_mid
        assign x_in[i][j] = rem[i+1][j-1];
        assign b_in       = b_out[i][j-1];
      end

      assign diff        = x_in[i][j] ^ d[j] ^ b_in;
      assign b_out[i][j] = (~x_in[i][j] & d[j]) | (~(x_in[i][j] ^ d[j]) & b_in);
      assign rem[i][j]   = q[i] ? diff : x_in[i][j];
    end

    // carried-out bit or no final borrow means the subtraction fits.
    if (i == W-1) begin : g_q_top
      assign q[i] = n[2*W-1] | ~b_out[i][W-1];
    end else begin : g_q_low
      assign q[i] = rem[i+1][W-1] | ~b_out[i][W-1];
    end
  end

  assign r = rem[0];  // remainder is row 0.

endmodule

`default_nettype wire

/* hw/approx_array_div.sv */
`default_nettype none

module approx_array_div #(
  parameter int tri_size = 4
) (
  input  wire [div_pkg::DIVIDEND_W-1:0] n,
  input  wire [div_pkg::DIVISOR_W-1:0]  d,
  output wire [div_pkg::DIVISOR_W-1:0]  q,
  output wire [div_pkg::DIVISOR_W-1:0]  r
);

  localparam int W = div_pkg::DIVISOR_W;

  // row i gives quotient bit i and column j uses divisor bit j.
  wire [W-1:0] cx [W];  // minuend into each cell.
  wire [W-1:0] cb [W];  // borrow out.
  wire [W-1:0] cr [W];  // partial remainder after restore.

  // ==================================================
  // cell array
  // ==================================================
  for (genvar i = 0; i < W; i++) begin : g_row
    for (genvar j = 0; j < W; j++) begin : g_col
      wire b_in;

      if (j == 0) begin : g_lsb
        assign cx[i][j] = n[i];
        assign b_in     = 1'b0;
      end else if (i == W-1) begin : g_top
        assign cx[i][j] = n[W-1+j];  // top row reads the dividend directly.
        assign b_in     = cb[i][j-1];
      end else begin : g_mid
        assign cx[i][j] = cr[i+1][j-1];
        assign b_in     = cb[i][j-1];
      end

      if (i + j < tri_size) begin : g_apx
        // low corner cell passes x through whatever the quotient bit.
        assign cb[i][j] = ~b_in;
        assign cr[i][j] = cx[i][j];
      end else begin : g_exa
        wire diff;

        assign diff     = cx[i][j] ^ d[j] ^ b_in;
        assign cb[i][j] = (~cx[i][j] & d[j]) | (~(cx[i][j] ^ d[j]) & b_in);
        assign cr[i][j] = q[i] ? diff : cx[i][j];  // restore on q = 0.
      end
    end

    // quotient bit.
    if (i == W-1) begin : g_q_top
      assign q[i] = n[2*W-1] | ~cb[i][W-1];
    end else begin : g_q_low
      assign q[i] = cr[i+1][W-1] | ~cb[i][W-1];
    end
  end

  assign r = cr[0];

endmodule

`default_nettype wire

/* hw/div_ctrl.sv */
`default_nettype none

module div_ctrl (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             start,
  input  wire div_pkg::div_op_e           op,
  input  wire [div_pkg::DIVIDEND_W-1:0]   n,
  input  wire [div_pkg::DIVISOR_W-1:0]    d,
  input  wire [div_pkg::DIVISOR_W-1:0]    q_arr,
  input  wire [div_pkg::DIVISOR_W-1:0]    r_arr,
  input  wire [div_pkg::DIVISOR_W-1:0]    q_apx_arr,
  input  wire [div_pkg::DIVISOR_W-1:0]    r_apx_arr,
  output logic [div_pkg::DIVIDEND_W-1:0]  n_reg,
  output logic [div_pkg::DIVISOR_W-1:0]   d_reg,
  output logic                            busy,
  output logic                            done,
  output logic                            ovf,
  output logic [div_pkg::DIVISOR_W-1:0]   q,
  output logic [div_pkg::DIVISOR_W-1:0]   r,
  output logic [div_pkg::DIVISOR_W-1:0]   q_apx,
  output logic [div_pkg::DIVISOR_W-1:0]   r_apx,
  output logic                            meter_upd,
  output logic                            meter_clr
);

  div_pkg::ctrl_state_e state;
  div_pkg::div_op_e     op_reg;
  logic                 ovf_c;
  logic                 use_exact;
  logic                 use_apx;

  // quotient would not fit in 8 bits.
  assign ovf_c = (d_reg == '0) ||
                 (n_reg[div_pkg::DIVIDEND_W-1 -: div_pkg::DIVISOR_W] >= d_reg);

  assign use_exact = (op_reg == div_pkg::op_exact) || (op_reg == div_pkg::op_compare);
  assign use_apx   = (op_reg == div_pkg::op_approx) || (op_reg == div_pkg::op_compare);
  assign busy      = (state != div_pkg::st_idle);

  // ==================================================
  // state machine
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= div_pkg::st_idle;
      done      <= 1'b0;
      ovf       <= 1'b0;
      meter_upd <= 1'b0;
      meter_clr <= 1'b0;
    end else begin
      done      <= 1'b0;
      meter_upd <= 1'b0;
      meter_clr <= 1'b0;
      case (state)
        div_pkg::st_idle: begin
          if (start) state <= div_pkg::st_calc;
        end
        div_pkg::st_calc: begin
          ovf       <= ovf_c;
          meter_upd <= (op_reg == div_pkg::op_compare) && !ovf_c;
          meter_clr <= (op_reg == div_pkg::op_clear);
          state     <= div_pkg::st_done;
        end
        div_pkg::st_done: begin
          done  <= 1'b1;  // lines up with the meter update edge.
          state <= div_pkg::st_idle;
        end
        default: state <= div_pkg::st_idle;
      endcase
    end
  end

  // ==================================================
  // operand and result registers
  // ==================================================
  always_ff @(posedge clk) begin
    if (state == div_pkg::st_idle && start) begin
      n_reg  <= n;
      d_reg  <= d;
      op_reg <= op;
    end
    if (state == div_pkg::st_calc && use_exact) begin
      q <= q_arr;
      r <= r_arr;
    end
    if (state == div_pkg::st_calc && use_apx) begin
      q_apx <= q_apx_arr;
      r_apx <= r_apx_arr;
    end
  end

endmodule

`default_nettype wire

/* hw/div_error_meter.sv */
`default_nettype none

module div_error_meter (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           upd,
  input  wire                           clr,
  input  wire [div_pkg::DIVISOR_W-1:0]  q_ex,
  input  wire [div_pkg::DIVISOR_W-1:0]  q_ap,
  output logic [div_pkg::ERR_W-1:0]     err_sum,
  output logic [div_pkg::DIVISOR_W-1:0] err_max,
  output logic [div_pkg::CNT_W-1:0]     mismatch_cnt
);

  localparam int W  = div_pkg::DIVISOR_W;
  localparam int EW = div_pkg::ERR_W;

  logic [W-1:0] abs_diff;
  logic [EW:0]  sum_ext;  // one spare bit for the carry.

  // ==================================================
  // error of one compare
  // ==================================================
  assign abs_diff = (q_ex >= q_ap) ? (q_ex - q_ap) : (q_ap - q_ex);
  assign sum_ext  = {1'b0, err_sum} + {{(EW+1-W){1'b0}}, abs_diff};

  // ==================================================
  // statistics
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      err_sum      <= '0;
      err_max      <= '0;
      mismatch_cnt <= '0;
    end else if (upd) begin
      // saturate rather than wrap.
      if (sum_ext[EW]) begin
        err_sum <= '1;
      end else begin
        err_sum <= sum_ext[EW-1:0];
      end
      if (abs_diff > err_max) err_max <= abs_diff;
      if (abs_diff != '0 && mismatch_cnt != '1) begin
        mismatch_cnt <= mismatch_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/div_unit_top.sv */
`default_nettype none

module div_unit_top #(
  parameter int tri_size = 4
) (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             start,
  input  wire div_pkg::div_op_e           op,
  input  wire [div_pkg::DIVIDEND_W-1:0]   n,
  input  wire [div_pkg::DIVISOR_W-1:0]    d,
  output wire                             busy,
  output wire                             done,
  output wire                             ovf,
  output wire [div_pkg::DIVISOR_W-1:0]    q,
  output wire [div_pkg::DIVISOR_W-1:0]    r,
  output wire [div_pkg::DIVISOR_W-1:0]    q_apx,
  output wire [div_pkg::DIVISOR_W-1:0]    r_apx,
  output wire [div_pkg::ERR_W-1:0]        err_sum,
  output wire [div_pkg::DIVISOR_W-1:0]    err_max,
  output wire [div_pkg::CNT_W-1:0]        mismatch_cnt
);

  wire [div_pkg::DIVIDEND_W-1:0] n_reg;
  wire [div_pkg::DIVISOR_W-1:0]  d_reg;
  wire [div_pkg::DIVISOR_W-1:0]  q_arr, r_arr;
  wire [div_pkg::DIVISOR_W-1:0]  q_apx_arr, r_apx_arr;
  wire                           meter_upd, meter_clr;

  div_ctrl u_ctrl (
    .clk(clk), .rst(rst), .start(start), .op(op), .n(n), .d(d),
    .q_arr(q_arr), .r_arr(r_arr), .q_apx_arr(q_apx_arr), .r_apx_arr(r_apx_arr),
    .n_reg(n_reg), .d_reg(d_reg), .busy(busy), .done(done), .ovf(ovf),
    .q(q), .r(r), .q_apx(q_apx), .r_apx(r_apx),
    .meter_upd(meter_upd), .meter_clr(meter_clr)
  );

  // both arrays see the registered operands.
  exact_array_div u_exact (.n(n_reg), .d(d_reg), .q(q_arr), .r(r_arr));

  approx_array_div #(.tri_size(tri_size)) u_approx (
    .n(n_reg), .d(d_reg), .q(q_apx_arr), .r(r_apx_arr)
  );

  div_error_meter u_meter (
    .clk(clk), .rst(rst), .upd(meter_upd), .clr(meter_clr),
    .q_ex(q), .q_ap(q_apx),
    .err_sum(err_sum), .err_max(err_max), .mismatch_cnt(mismatch_cnt)
  );

endmodule

`default_nettype wire

/* verification/div_unit_asserts.sv */
`default_nettype none

module div_unit_asserts (
  input wire                           clk,
  input wire                           rst,
  input wire                           start,
  input wire                           busy,
  input wire                           done,
  input wire                           ovf,
  input wire [div_pkg::ERR_W-1:0]      err_sum,
  input wire [div_pkg::DIVISOR_W-1:0]  err_max,
  input wire [div_pkg::CNT_W-1:0]      mismatch_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // watched from the testbench top.

  // ==================================================
  // reset state and start/done timing
  // ==================================================
  a_reset_state: assert property (@(posedge clk)
    rst |=> (!busy && !done && !ovf && err_sum == '0 && err_max == '0 && mismatch_cnt == '0))
    else begin
      fail_cnt++;
      $error("busy, done, ovf or statistics not cleared by reset");
    end

  a_start_to_done: assert property (@(posedge clk) disable iff (rst)
    (start && !busy) |=> (busy && !done) ##1 (busy && !done) ##1 (done && !busy))
    else begin
      fail_cnt++;
      $error("done did not follow an accepted start by exactly two cycles");
    end

  // a start seen while busy must not stretch the operation.
  a_busy_two_cycles: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> ##1 busy ##1 !busy)
    else begin
      fail_cnt++;
      $error("busy was not high for exactly two cycles");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      fail_cnt++;
      $error("done stayed high for more than one cycle");
    end

  // ==================================================
  // statistics only move as done rises
  // ==================================================
  a_stats_at_done: assert property (@(posedge clk) disable iff (rst)
    (!$stable(err_sum) || !$stable(err_max) || !$stable(mismatch_cnt)) |-> done)
    else begin
      fail_cnt++;
      $error("statistics changed outside the done cycle");
    end

endmodule

`default_nettype wire

/* verification/tb_div_unit.sv */
`default_nettype none

module tb_div_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TRI_SIZE = 4;
  localparam int N_OPS    = 48;
  localparam int CLK_NS   = 4;

  logic                              clk;
  logic                              rst;
  logic                              start;
  div_pkg::div_op_e                  op;
  logic [div_pkg::DIVIDEND_W-1:0]    n;
  logic [div_pkg::DIVISOR_W-1:0]     d;
  wire                               busy, done, ovf;
  wire [div_pkg::DIVISOR_W-1:0]      q, r, q_apx, r_apx;
  wire [div_pkg::ERR_W-1:0]          err_sum;
  wire [div_pkg::DIVISOR_W-1:0]      err_max;
  wire [div_pkg::CNT_W-1:0]          mismatch_cnt;

  logic [31:0] lfsr = 32'hc27a;
  logic [31:0] sh_sum;  // shadow statistics.
  logic [7:0]  sh_max;
  logic [15:0] sh_cnt;
  logic [7:0]  prev_q, prev_r, prev_qa, prev_ra;

  div_unit_top #(.tri_size(TRI_SIZE)) DUT (
    .clk(clk), .rst(rst), .start(start), .op(op), .n(n), .d(d),
    .busy(busy), .done(done), .ovf(ovf), .q(q), .r(r), .q_apx(q_apx), .r_apx(r_apx),
    .err_sum(err_sum), .err_max(err_max), .mismatch_cnt(mismatch_cnt)
  );

  bind div_unit_top div_unit_asserts u_asserts (
    .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done), .ovf(ovf),
    .err_sum(err_sum), .err_max(err_max), .mismatch_cnt(mismatch_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #((N_OPS * 3 + 50) * CLK_NS);
    $display("watchdog expired before all operations finished");
    end_with_failure();
  end

  always @(negedge clk) begin
    if (DUT.u_asserts.fail_cnt != 0) end_with_failure();
  end

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    assert (got_v === exp_v) else begin
      $display("ERROR %s exp %h got %h", name, exp_v, got_v);
      end_with_failure();
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit.
  function automatic logic [15:0] take_bits(input int width);
    logic [15:0] val;
    val = '0;
    for (int k = 0; k < width; k++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val  = {val[14:0], lfsr[31]};
    end
    return val;
  endfunction

  // ==================================================
  // bit-level array model, row by row
  // ==================================================
  function automatic void array_model(input logic [15:0] nv, input logic [7:0] dv,
                                      input int apx, output logic [7:0] qv,
                                      output logic [7:0] rv);
    logic [7:0] x;
    logic [7:0] diff;
    logic       top;
    logic       b;
    x   = nv[14:7];
    top = nv[15];
    for (int i = 7; i >= 0; i--) begin
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        if (i + j < apx) begin
          diff[j] = x[j];  // approximate cell.
          b       = ~b;
        end else begin
          diff[j] = x[j] ^ dv[j] ^ b;
          b       = (~x[j] & dv[j]) | (~(x[j] ^ dv[j]) & b);
        end
      end
      qv[i] = top | ~b;
      if (qv[i]) x = diff;
      if (i > 0) begin
        top = x[7];
        x   = {x[6:0], nv[i-1]};
      end
    end
    rv = x;
  endfunction

  task automatic run_op(input div_pkg::div_op_e op_v, input logic [15:0] nv,
                        input logic [7:0] dv, input bit hold);
    int         waited;
    logic       exp_ovf;
    logic [7:0] qa_m, ra_m, diff;
    waited = 0;
    op     = op_v;
    n      = nv;
    d      = dv;
    start  = 1'b1;
    @(negedge clk);
    if (hold) begin
      n = ~nv;  // busy now, must be ignored.
      d = dv ^ 8'h5a;
    end else begin
      start = 1'b0;
    end
    @(negedge clk);
    start = 1'b0;
    while (done !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > 4) begin
        $display("done never rose after an accepted start");
        end_with_failure();
      end
    end
    exp_ovf = (dv == 8'd0) || (nv[15:8] >= dv);
    check_val("ovf", exp_ovf, ovf);
    if (op_v inside {div_pkg::op_exact, div_pkg::op_compare}) begin
      if (!exp_ovf) begin
        check_val("q", nv / dv, q);
        check_val("r", nv % dv, r);
      end
    end else begin
      check_val("q", prev_q, q);
      check_val("r", prev_r, r);
    end
    if (op_v inside {div_pkg::op_approx, div_pkg::op_compare}) begin
      if (!exp_ovf) begin
        array_model(nv, dv, TRI_SIZE, qa_m, ra_m);
        check_val("q_apx", qa_m, q_apx);
        check_val("r_apx", ra_m, r_apx);
      end
    end else begin
      check_val("q_apx", prev_qa, q_apx);
      check_val("r_apx", prev_ra, r_apx);
    end
    if (op_v == div_pkg::op_clear) begin
      sh_sum = '0;
      sh_max = '0;
      sh_cnt = '0;
    end else if (op_v == div_pkg::op_compare && !exp_ovf) begin
      diff   = (q >= q_apx) ? q - q_apx : q_apx - q;
      sh_sum = (sh_sum + diff > 32'hff_ffff) ? 32'hff_ffff : sh_sum + diff;
      if (diff > sh_max) sh_max = diff;
      if (diff != 0 && sh_cnt != 16'hffff) sh_cnt++;
    end
    check_val("err_sum", sh_sum, err_sum);
    check_val("err_max", sh_max, err_max);
    check_val("mismatch_cnt", sh_cnt, mismatch_cnt);
    prev_q  = q;
    prev_r  = r;
    prev_qa = q_apx;
    prev_ra = r_apx;
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    div_pkg::div_op_e op_v;
    logic [7:0]       dv, hi, lo;
    rst    = 1'b1;
    start  = 1'b0;
    op     = div_pkg::op_exact;
    n      = '0;
    d      = '0;
    sh_sum = '0;
    sh_max = '0;
    sh_cnt = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < N_OPS; k++) begin
      op_v = div_pkg::div_op_e'(take_bits(2));
      if (k % 8 == 7) op_v = div_pkg::op_clear;
      else if (op_v == div_pkg::op_clear) op_v = div_pkg::op_compare;
      if (k % 10 == 3) op_v = div_pkg::op_compare;  // compare with overflow.
      dv = 8'(take_bits(8));
      hi = 8'(take_bits(8));
      lo = 8'(take_bits(8));
      if (k % 10 == 6) dv = 8'd0;  // divide by zero.
      else if (dv == 8'd0) dv = 8'd1;
      if (k % 10 == 3) begin
        if (hi < dv) hi = dv;
      end else if (dv != 8'd0) begin
        hi = hi % dv;
      end
      run_op(op_v, {hi, lo}, dv, k % 5 == 2);
    end
    @(negedge clk);
    if (DUT.u_asserts.fail_cnt == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

/* build.f */
hw/div_pkg.sv
hw/exact_array_div.sv
hw/approx_array_div.sv
hw/div_ctrl.sv
hw/div_error_meter.sv
hw/div_unit_top.sv
verification/div_unit_asserts.sv
verification/tb_div_unit.sv

/* Bender.yml */
package:
  name: div_unit

sources:
  - hw/div_pkg.sv
  - hw/exact_array_div.sv
  - hw/approx_array_div.sv
  - hw/div_ctrl.sv
  - hw/div_error_meter.sv
  - hw/div_unit_top.sv
  - target: simulation
    files:
      - verification/div_unit_asserts.sv
      - verification/tb_div_unit.sv
